/* cgra.sv */
`timescale 1ns/1ps

`include "cgra_defs.svh"

module cgra
  import cgra_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  conf_byte_t i_conf_bus,
  input  data_t      i_stream0,
  input  data_t      i_stream3,
  input  data_t      i_stream6,
  output data_t      o_stream2,
  output data_t      o_stream5,
  output data_t      o_stream8
);

  conf_byte_t conf [`CGRA_NUM_PE];
  data_t      result [`CGRA_NUM_PE];

  conf_chain u_conf_chain (
    .clk        (clk),
    .rst        (rst),
    .i_conf_bus (i_conf_bus),
    .o_conf     (conf)
  );

  // ========================================
  // source lists
  // ========================================

  // stream first on the left column, then neighbours by ascending index.
  data_t src0 [3];
  data_t src1 [3];
  data_t src2 [2];
  data_t src3 [4];
  data_t src4 [4];
  data_t src5 [3];
  data_t src6 [3];
  data_t src7 [3];
  data_t src8 [2];

  assign src0 = '{i_stream0, result[1], result[3]};
  assign src1 = '{result[0], result[2], result[4]};
  assign src2 = '{result[1], result[5]};
  assign src3 = '{i_stream3, result[0], result[4], result[6]};
  assign src4 = '{result[1], result[3], result[5], result[7]};
  assign src5 = '{result[2], result[4], result[8]};
  assign src6 = '{i_stream6, result[3], result[7]};
  assign src7 = '{result[4], result[6], result[8]};
  assign src8 = '{result[5], result[7]};

  // ========================================
  // processing elements
  // ========================================

  pe #(.PE_ID(4'd1), .NUM_SRC(3)) u_pe0 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[0]),
    .i_src    (src0),
    .o_result (result[0])
  );

  pe #(.PE_ID(4'd2), .NUM_SRC(3)) u_pe1 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[1]),
    .i_src    (src1),
    .o_result (result[1])
  );

  pe #(.PE_ID(4'd3), .NUM_SRC(2)) u_pe2 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[2]),
    .i_src    (src2),
    .o_result (result[2])
  );

  pe #(.PE_ID(4'd4), .NUM_SRC(4)) u_pe3 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[3]),
    .i_src    (src3),
    .o_result (result[3])
  );

  pe #(.PE_ID(4'd5), .NUM_SRC(4)) u_pe4 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[4]),
    .i_src    (src4),
    .o_result (result[4])
  );

  pe #(.PE_ID(4'd6), .NUM_SRC(3)) u_pe5 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[5]),
    .i_src    (src5),
    .o_result (result[5])
  );

  pe #(.PE_ID(4'd7), .NUM_SRC(3)) u_pe6 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[6]),
    .i_src    (src6),
    .o_result (result[6])
  );

  pe #(.PE_ID(4'd8), .NUM_SRC(3)) u_pe7 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[7]),
    .i_src    (src7),
    .o_result (result[7])
  );

  pe #(.PE_ID(4'd9), .NUM_SRC(2)) u_pe8 (
    .clk      (clk),
    .rst      (rst),
    .i_conf   (conf[8]),
    .i_src    (src8),
    .o_result (result[8])
  );

  assign o_stream2 = result[2];
  assign o_stream5 = result[5];
  assign o_stream8 = result[8];

endmodule

/* cgra_defs.svh */
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// ========================================
// datapath
// ========================================

`define CGRA_DATA_W 8

// ========================================
// mesh geometry
// ========================================

`define CGRA_ROWS 3
`define CGRA_COLS 3
`define CGRA_NUM_PE 9

// ========================================
// configuration fields
// ========================================

// pe ids run from 1, so id 0 addresses no pe.
`define CGRA_ID_W 4
`define CGRA_SEL_W 3
`define CGRA_ALU_LAT 3

`endif

/* cgra_pkg.sv */
package cgra_pkg;

  `include "cgra_defs.svh"

  typedef logic [`CGRA_DATA_W-1:0] data_t;
  typedef logic [`CGRA_DATA_W-1:0] conf_byte_t;
  typedef logic [`CGRA_DATA_W-2:0] payload_t;
  typedef logic [2*(`CGRA_DATA_W-1)-1:0] frame_t;
  typedef logic [`CGRA_ID_W-1:0] pe_id_t;
  typedef logic [`CGRA_SEL_W-1:0] sel_t;

  // opcode in bits 1:0, select a in 4:2, select b in 7:5.
  typedef logic [`CGRA_DATA_W-1:0] alu_conf_t;

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_MUL  = 2'd1,
    OP_SUB  = 2'd2,
    OP_NONE = 2'd3
  } opcode_e;

  typedef enum logic [1:0] {
    CMD_CLEAR = 2'd0,
    CMD_ALU   = 2'd1,
    CMD_CONST = 2'd2,
    CMD_NONE  = 2'd3
  } conf_cmd_e;

  typedef enum logic {
    PH_HIGH = 1'b0,
    PH_LOW  = 1'b1
  } frame_phase_e;

endpackage

/* conf_chain.sv */
`timescale 1ns/1ps

`include "cgra_defs.svh"

module conf_chain
  import cgra_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  conf_byte_t i_conf_bus,
  output conf_byte_t o_conf [`CGRA_NUM_PE]
);

  // the bus enters at pe 0 and walks down column 0, then along each row.
  // every pe therefore sees it 1 + row + column cycles late.
  for (genvar r = 0; r < `CGRA_ROWS; r++) begin : g_row
    for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_col
      localparam int IDX = r * `CGRA_COLS + c;

      conf_byte_t conf_d;

      if (IDX == 0) begin : g_root
        assign conf_d = i_conf_bus;
      end else if (c == 0) begin : g_from_above
        assign conf_d = o_conf[IDX - `CGRA_COLS];
      end else begin : g_from_left
        assign conf_d = o_conf[IDX - 1];
      end

      always_ff @(posedge clk) begin
        if (rst) begin
          o_conf[IDX] <= '0;
        end else begin
          o_conf[IDX] <= conf_d;
        end
      end
    end
  end

endmodule

/* conf_reader.sv */
`timescale 1ns/1ps

module conf_reader
  import cgra_pkg::*;
#(
  parameter pe_id_t PE_ID = 1
)
(
  input  logic       clk,
  input  logic       rst,
  input  conf_byte_t i_conf,
  output alu_conf_t  o_alu_conf,
  output data_t      o_const
);

  frame_phase_e phase_q;
  payload_t     high_q;

  logic         byte_valid;
  payload_t     byte_payload;
  frame_t       frame;
  pe_id_t       frame_id;
  conf_cmd_e    frame_cmd;
  data_t        frame_data;

  assign byte_valid   = i_conf[0];
  assign byte_payload = i_conf[7:1];

  // the frame is decoded from the stored high half and the byte on the bus,
  // so a command acts on the same edge that takes its second byte.
  assign frame      = {high_q, byte_payload};
  assign frame_id   = frame[3:0];
  assign frame_cmd  = conf_cmd_e'(frame[5:4]);
  assign frame_data = frame[13:6];

  // ========================================
  // deframer and command decode
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q    <= PH_HIGH;
      high_q     <= '0;
      o_alu_conf <= '0;
      o_const    <= '0;
    end else if (byte_valid) begin
      case (phase_q)
        PH_HIGH: begin
          high_q  <= byte_payload;
          phase_q <= PH_LOW;
        end
        PH_LOW: begin
          phase_q <= PH_HIGH;
          if (frame_id == PE_ID) begin
            case (frame_cmd)
              CMD_CLEAR: begin
                o_alu_conf <= '0;
                o_const    <= '0;
              end
              CMD_ALU: begin
                o_alu_conf <= frame_data;
              end
              CMD_CONST: begin
                o_const <= frame_data;
              end
              default: begin
                o_const <= o_const;
              end
            endcase
          end
        end
        default: begin
          phase_q <= PH_HIGH;
        end
      endcase
    end
  end

endmodule

/* files.f */
+incdir+.
cgra_pkg.sv
conf_chain.sv
conf_reader.sv
pe_alu.sv
pe.sv
cgra.sv
tb_cgra.sv

/* pe.sv */
`timescale 1ns/1ps

module pe
  import cgra_pkg::*;
#(
  parameter pe_id_t PE_ID   = 1,
  parameter int     NUM_SRC = 2
)
(
  input  logic       clk,
  input  logic       rst,
  input  conf_byte_t i_conf,
  input  data_t      i_src [NUM_SRC],
  output data_t      o_result
);

  alu_conf_t alu_conf;
  data_t     pe_const;
  opcode_e   opcode;
  sel_t      sel_a;
  sel_t      sel_b;
  data_t     op_a;
  data_t     op_b;

  conf_reader #(
    .PE_ID (PE_ID)
  ) u_conf_reader (
    .clk        (clk),
    .rst        (rst),
    .i_conf     (i_conf),
    .o_alu_conf (alu_conf),
    .o_const    (pe_const)
  );

  assign opcode = opcode_e'(alu_conf[1:0]);
  assign sel_a  = alu_conf[4:2];
  assign sel_b  = alu_conf[7:5];

  // code 0 is the constant and code k is source k-1.
  // Anything past the last source reads as zero.
  function automatic data_t pick_operand(input sel_t sel);
    data_t val;
    val = '0;
    if (sel == '0) begin
      val = pe_const;
    end
    for (int k = 0; k < NUM_SRC; k++) begin
      if (sel == sel_t'(k + 1)) begin
        val = i_src[k];
      end
    end
    return val;
  endfunction

  always_comb begin
    op_a = pick_operand(sel_a);
    op_b = pick_operand(sel_b);
  end

  pe_alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .i_opcode (opcode),
    .i_a      (op_a),
    .i_b      (op_b),
    .o_result (o_result)
  );

endmodule

/* pe_alu.sv */
`timescale 1ns/1ps

module pe_alu
  import cgra_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  opcode_e i_opcode,
  input  data_t   i_a,
  input  data_t   i_b,
  output data_t   o_result
);

  data_t a_q;
  data_t b_q;
  data_t add_q;
  data_t mul_q;
  data_t sub_q;
  data_t add_r;
  data_t mul_r;
  data_t sub_r;

  // three register stages: operands, raw results, stored results.
  always_ff @(posedge clk) begin
    if (rst) begin
      a_q   <= '0;
      b_q   <= '0;
      add_q <= '0;
      mul_q <= '0;
      sub_q <= '0;
      add_r <= '0;
      mul_r <= '0;
      sub_r <= '0;
    end else begin
      a_q   <= i_a;
      b_q   <= i_b;
      add_q <= a_q + b_q;
      mul_q <= a_q * b_q;
      sub_q <= a_q - b_q;
      add_r <= add_q;
      mul_r <= mul_q;
      sub_r <= sub_q;
    end
  end

  // only the low byte of the product is kept.
  always_comb begin
    case (i_opcode)
      OP_ADD:  o_result = add_r;
      OP_MUL:  o_result = mul_r;
      OP_SUB:  o_result = sub_r;
      default: o_result = '0;
    endcase
  end

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_cgra -o sim_cgra
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_cgra > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

/* tb_cgra.sv */
`timescale 1ns/1ps

`include "cgra_defs.svh"

module tb_cgra
  import cgra_pkg::*;
;

  localparam int NPE = `CGRA_NUM_PE;
  localparam int ROWS = `CGRA_ROWS;
  localparam int COLS = `CGRA_COLS;
  localparam int LAT = `CGRA_ALU_LAT;
  localparam int CLK_PERIOD = 20;
  localparam int SETTLE = 40;
  localparam int NUM_FRAMES = 15;
  localparam int TEST_CYCLES = 4 + NUM_FRAMES * 4 + 6 * SETTLE + 1;

  logic        clk;
  logic        rst;
  conf_byte_t  i_conf_bus;
  data_t       i_stream0;
  data_t       i_stream3;
  data_t       i_stream6;
  data_t       o_stream2;
  data_t       o_stream5;
  data_t       o_stream8;
  int          errors = 0;
  string       test_name = "reset";
  logic [31:0] rng_state;

  // reference model state.
  conf_byte_t  dl [ROWS + COLS - 1];
  logic        m_phase [NPE];
  payload_t    m_high [NPE];
  alu_conf_t   m_conf [NPE];
  data_t       m_const [NPE];
  data_t       m_add [NPE][LAT];
  data_t       m_mul [NPE][LAT];
  data_t       m_sub [NPE][LAT];
  data_t       exp_out [NPE];

  cgra dut (
    .clk        (clk),
    .rst        (rst),
    .i_conf_bus (i_conf_bus),
    .i_stream0  (i_stream0),
    .i_stream3  (i_stream3),
    .i_stream6  (i_stream6),
    .o_stream2  (o_stream2),
    .o_stream5  (o_stream5),
    .o_stream8  (o_stream8)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ========================================
  // reference model
  // ========================================

  function automatic data_t model_out(input int p);
    case (opcode_e'(m_conf[p][1:0]))
      OP_ADD:  return m_add[p][LAT-1];
      OP_MUL:  return m_mul[p][LAT-1];
      OP_SUB:  return m_sub[p][LAT-1];
      default: return '0;
    endcase
  endfunction

  // left column PEs see their stream first, then neighbours by index.
  function automatic data_t model_src(input int p, input int k);
    data_t list [$];
    int    r;
    int    c;
    r = p / COLS;
    c = p % COLS;
    if (c == 0) list.push_back(r == 0 ? i_stream0 : (r == 1 ? i_stream3 : i_stream6));
    if (r > 0) list.push_back(model_out(p - COLS));
    if (c > 0) list.push_back(model_out(p - 1));
    if (c < COLS - 1) list.push_back(model_out(p + 1));
    if (r < ROWS - 1) list.push_back(model_out(p + COLS));
    if (k < list.size()) return list[k];
    return '0;
  endfunction

  function automatic data_t model_operand(input int p, input sel_t sel);
    if (sel == '0) return m_const[p];
    return model_src(p, int'(sel) - 1);
  endfunction

  always @(posedge clk) begin : model_step
    data_t      a;
    data_t      b;
    frame_t     f;
    conf_byte_t cb;
    if (rst) begin
      for (int k = 0; k < ROWS + COLS - 1; k++) dl[k] <= '0;
      for (int p = 0; p < NPE; p++) begin
        m_phase[p] <= 1'b0;
        m_high[p]  <= '0;
        m_conf[p]  <= '0;
        m_const[p] <= '0;
        for (int s = 0; s < LAT; s++) begin
          m_add[p][s] <= '0;
          m_mul[p][s] <= '0;
          m_sub[p][s] <= '0;
        end
      end
    end else begin
      dl[0] <= i_conf_bus;
      for (int k = 1; k < ROWS + COLS - 1; k++) dl[k] <= dl[k-1];
      for (int p = 0; p < NPE; p++) begin
        a = model_operand(p, m_conf[p][4:2]);
        b = model_operand(p, m_conf[p][7:5]);
        m_add[p][0] <= a + b;
        m_mul[p][0] <= a * b;
        m_sub[p][0] <= a - b;
        for (int s = 1; s < LAT; s++) begin
          m_add[p][s] <= m_add[p][s-1];
          m_mul[p][s] <= m_mul[p][s-1];
          m_sub[p][s] <= m_sub[p][s-1];
        end
        // PE r*3+c sees the bus 1+r+c cycles late.
        cb = dl[p / COLS + p % COLS];
        if (cb[0] && !m_phase[p]) begin
          m_high[p]  <= cb[7:1];
          m_phase[p] <= 1'b1;
        end else if (cb[0]) begin
          m_phase[p] <= 1'b0;
          f = {m_high[p], cb[7:1]};
          if (f[3:0] == pe_id_t'(p + 1)) begin
            case (conf_cmd_e'(f[5:4]))
              CMD_CLEAR: begin
                m_conf[p]  <= '0;
                m_const[p] <= '0;
              end
              CMD_ALU:   m_conf[p] <= f[13:6];
              CMD_CONST: m_const[p] <= f[13:6];
              default:   m_const[p] <= m_const[p];
            endcase
          end
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NPE; p++) exp_out[p] = model_out(p);
  end

  // ========================================
  // checks
  // ========================================

  task automatic report_mismatch(input string port, input data_t expv, input data_t actv);
    errors++;
    $display("** Error [%s] %s: expected %02h, actual %02h", test_name, port, expv, actv);
  endtask

  a_stream2: assert property (@(posedge clk) disable iff (rst) o_stream2 === exp_out[2])
    else report_mismatch("o_stream2", $sampled(exp_out[2]), $sampled(o_stream2));
  a_stream5: assert property (@(posedge clk) disable iff (rst) o_stream5 === exp_out[5])
    else report_mismatch("o_stream5", $sampled(exp_out[5]), $sampled(o_stream5));
  a_stream8: assert property (@(posedge clk) disable iff (rst) o_stream8 === exp_out[8])
    else report_mismatch("o_stream8", $sampled(exp_out[8]), $sampled(o_stream8));

  // ========================================
  // stimulus
  // ========================================

  initial begin
    i_stream0 = '0;
    i_stream3 = '0;
    i_stream6 = '0;
    rng_state = 32'd567;
    forever begin
      @(posedge clk);
      rng_state = xorshift32(rng_state);
      i_stream0 <= rst ? '0 : rng_state[7:0];
      i_stream3 <= rst ? '0 : rng_state[15:8];
      i_stream6 <= rst ? '0 : rng_state[23:16];
    end
  end

  function automatic alu_conf_t mk_conf(input opcode_e op, input sel_t sa, input sel_t sb);
    return {sb, sa, op};
  endfunction

  task automatic send_byte(input conf_byte_t b);
    @(posedge clk);
    i_conf_bus <= b;
  endtask

  // a frame is sent high half first; an idle byte may sit between the halves.
  task automatic send_frame(input pe_id_t id, input conf_cmd_e cmd, input data_t data,
                            input bit gap);
    frame_t f;
    f = {data, cmd, id};
    send_byte({f[13:7], 1'b1});
    if (gap) send_byte(8'hfe);
    send_byte({f[6:0], 1'b1});
    send_byte('0);
  endtask

  task automatic settle();
    repeat (SETTLE) @(posedge clk);
  endtask

  initial begin
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst = 1'b1;
    i_conf_bus = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_name = "idle";
    settle();
    test_name = "pass_through";
    send_frame(4'd1, CMD_ALU, mk_conf(OP_ADD, 3'd1, 3'd0), 1'b0);
    send_frame(4'd2, CMD_ALU, mk_conf(OP_ADD, 3'd1, 3'd0), 1'b0);
    send_frame(4'd3, CMD_ALU, mk_conf(OP_ADD, 3'd1, 3'd0), 1'b0);
    settle();
    test_name = "row1_ops";
    send_frame(4'd4, CMD_CONST, 8'd3, 1'b0);
    send_frame(4'd4, CMD_ALU, mk_conf(OP_MUL, 3'd1, 3'd0), 1'b0);
    send_frame(4'd5, CMD_CONST, 8'd17, 1'b1);
    send_frame(4'd5, CMD_ALU, mk_conf(OP_SUB, 3'd2, 3'd0), 1'b0);
    send_frame(4'd6, CMD_ALU, mk_conf(OP_ADD, 3'd2, 3'd0), 1'b0);
    settle();
    test_name = "cross_row";
    send_frame(4'd7, CMD_ALU, mk_conf(OP_ADD, 3'd1, 3'd0), 1'b0);
    send_frame(4'd8, CMD_ALU, mk_conf(OP_ADD, 3'd2, 3'd0), 1'b0);
    send_frame(4'd9, CMD_ALU, mk_conf(OP_ADD, 3'd1, 3'd2), 1'b0);
    settle();
    test_name = "clear";
    send_frame(4'd6, CMD_CLEAR, 8'd0, 1'b0);
    settle();
    test_name = "ignored_frames";
    send_frame(4'd0, CMD_ALU, 8'hff, 1'b1);
    send_frame(4'd3, CMD_NONE, 8'hff, 1'b1);
    send_frame(4'd6, CMD_CONST, 8'h55, 1'b1);
    settle();
    // the falling edge lets the last rising edge's checks finish first.
    @(negedge clk);
    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
